//--- src.f
+incdir+verification
verilog/lsu_pkg.sv
verilog/lsu_req_fsm.sv
verilog/lsu_store_align.sv
verilog/lsu_load_align.sv
verilog/lsu_top.sv
verification/tb_lsu.sv

//--- verification/tb_lsu_tests.svh
/*
 * compare tasks, core-side access driver, reference model helpers
 * and directed tests for the load/store unit testbench
 */
`ifndef TB_LSU_TESTS_SVH
`define TB_LSU_TESTS_SVH

////////////////////
// compare tasks
////////////////////

task automatic check_data(input string what, input data_t got, input data_t exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Fail at %0d ns: %s is %08h, expected %08h", $time, what, got, exp);
  end
endtask

task automatic check_addr(input string what, input addr_t got, input addr_t exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Fail at %0d ns: %s is %08h, expected %08h", $time, what, got, exp);
  end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  check_cnt++;
  if (got !== exp) begin
    err_cnt++;
    $display("Fail at %0d ns: %s is %b, expected %b", $time, what, got, exp);
  end
endtask

////////////////////
// reference model
////////////////////

function automatic int access_bytes(input lsu_type_e typ);
  case (typ)
    LSU_WORD: return 4;
    LSU_HALF: return 2;
    default:  return 1;
  endcase
endfunction

// bytes from the byte address upward, little endian, then extended
function automatic data_t expected_load(input addr_t addr, input lsu_type_e typ,
                                        input logic sext);
  data_t v;
  int    n;
  int    k;
  n = access_bytes(typ);
  v = '0;
  for (k = 0; k < 4; k++) begin
    if (k < n) begin
      v[8*k +: 8] = ref_mem[int'(addr[7:0]) + k];
    end else if (sext && v[8*n-1]) begin
      v[8*k +: 8] = 8'hff;
    end
  end
  return v;
endfunction

task automatic ref_store(input addr_t addr, input lsu_type_e typ, input data_t wdata);
  int k;
  for (k = 0; k < access_bytes(typ); k++) begin
    ref_mem[int'(addr[7:0]) + k] = wdata[8*k +: 8];
  end
endtask

// whole bus memory against the byte model, so untouched lanes count too
task automatic check_memory();
  int    i;
  data_t exp;
  for (i = 0; i < MemWords; i++) begin
    exp = {ref_mem[4*i+3], ref_mem[4*i+2], ref_mem[4*i+1], ref_mem[4*i]};
    check_data($sformatf("memory word %0d", i), mem[i], exp);
  end
endtask

////////////////////
// core side driver
////////////////////

// one access, request held until done, then wait for the final response
task automatic run_access(input logic we, input lsu_type_e typ, input addr_t addr,
                          input data_t wdata, input logic sext, output data_t rdata,
                          output logic rvalid_ok, output logic lerr, output logic serr);
  addr_t next_addr;
  logic  done;
  logic  got_resp;
  next_addr = {addr[31:2], 2'b00} + 32'd4;
  done      = 1'b0;
  got_resp  = 1'b0;
  @(negedge clk_i);
  lsu_req_i         = 1'b1;
  lsu_we_i          = we;
  lsu_type_i        = typ;
  lsu_wdata_i       = wdata;
  lsu_sign_ext_i    = sext;
  adder_result_ex_i = addr;
  while (!done) begin
    @(posedge clk_i);
    done = lsu_req_done_o;
    @(negedge clk_i);
    if (done) begin
      lsu_req_i = 1'b0;
    end else if (addr_incr_req_o) begin
      // second half wants the next word address
      adder_result_ex_i = next_addr;
    end else begin
      adder_result_ex_i = addr;
    end
  end
  while (!got_resp) begin
    @(posedge clk_i);
    if (lsu_resp_valid_o) begin
      got_resp  = 1'b1;
      rdata     = lsu_rdata_o;
      rvalid_ok = lsu_rdata_valid_o;
      lerr      = load_err_o;
      serr      = store_err_o;
    end
  end
  @(negedge clk_i);
  check_bit("busy after final response", busy_o, 1'b0);
endtask

task automatic store_and_check(input addr_t addr, input lsu_type_e typ, input data_t wdata);
  data_t rd;
  logic  ok;
  logic  lerr;
  logic  serr;
  run_access(1'b1, typ, addr, wdata, 1'b0, rd, ok, lerr, serr);
  check_bit("store error", serr, 1'b0);
  check_bit("data valid on store", ok, 1'b0);
  ref_store(addr, typ, wdata);
  check_memory();
endtask

task automatic load_and_check(input addr_t addr, input lsu_type_e typ, input logic sext);
  data_t rd;
  logic  ok;
  logic  lerr;
  logic  serr;
  run_access(1'b0, typ, addr, '0, sext, rd, ok, lerr, serr);
  check_bit("load error", lerr, 1'b0);
  check_bit("read data valid", ok, 1'b1);
  check_data($sformatf("load at %08h", addr), rd, expected_load(addr, typ, sext));
endtask

// two bus words, consecutive, plus the increment request
task automatic split_load_check(input addr_t addr, input lsu_type_e typ, input logic sext);
  addr_t base;
  base = {addr[31:2], 2'b00};
  gnt_addr_q.delete();
  incr_seen = 1'b0;
  load_and_check(addr, typ, sext);
  check_data("bus requests of split load", data_t'(gnt_addr_q.size()), 32'd2);
  if (gnt_addr_q.size() == 2) begin
    check_addr("first bus address", gnt_addr_q[0], base);
    check_addr("second bus address", gnt_addr_q[1], base + 32'd4);
  end
  check_bit("address increment seen", incr_seen, 1'b1);
endtask

task automatic start_test();
  test_start_err = err_cnt;
  test_cnt++;
endtask

task automatic report_test(input string name);
  if (err_cnt == test_start_err) begin
    $display("test %s: ok", name);
  end else begin
    $display("test %s: %0d errors", name, err_cnt - test_start_err);
  end
endtask

////////////////////
// directed tests
////////////////////

task automatic test_word_store_load();
  start_test();
  store_and_check(32'h10, LSU_WORD, 32'hcafe_f00d);
  load_and_check(32'h10, LSU_WORD, 1'b0);
  report_test("aligned word store and load");
endtask

task automatic test_sub_word();
  addr_t a;
  int    off;
  start_test();
  // byte values with the sign bit set
  for (off = 0; off < 4; off++) begin
    a = 32'h20 + off;
    store_and_check(a, LSU_BYTE, 32'h5a5a_5a81 + (off << 4));
    load_and_check({a[31:2], 2'b00}, LSU_WORD, 1'b0);
    load_and_check(a, LSU_BYTE, 1'b0);
    load_and_check(a, LSU_BYTE, 1'b1);
  end
  for (off = 0; off < 3; off++) begin
    a = 32'h30 + off;
    store_and_check(a, LSU_HALF, 32'h3c3c_8421 + off * 32'h1111);
    load_and_check({a[31:2], 2'b00}, LSU_WORD, 1'b0);
    load_and_check(a, LSU_HALF, 1'b0);
    load_and_check(a, LSU_HALF, 1'b1);
  end
  // positive values must not be extended with ones
  store_and_check(32'h25, LSU_BYTE, 32'hffff_ff7e);
  load_and_check(32'h25, LSU_BYTE, 1'b1);
  store_and_check(32'h36, LSU_HALF, 32'hffff_1234);
  load_and_check(32'h36, LSU_HALF, 1'b1);
  report_test("byte and half-word");
endtask

task automatic test_misaligned_load();
  start_test();
  split_load_check(32'h41, LSU_WORD, 1'b0);
  split_load_check(32'h4a, LSU_WORD, 1'b0);
  split_load_check(32'h57, LSU_WORD, 1'b0);
  split_load_check(32'h5b, LSU_HALF, 1'b1);
  split_load_check(32'h5f, LSU_HALF, 1'b0);
  report_test("misaligned loads");
endtask

task automatic test_misaligned_store();
  start_test();
  store_and_check(32'h61, LSU_WORD, 32'h1122_3344);
  load_and_check(32'h61, LSU_WORD, 1'b0);
  store_and_check(32'h72, LSU_WORD, 32'h5566_7788);
  load_and_check(32'h72, LSU_WORD, 1'b0);
  store_and_check(32'h87, LSU_WORD, 32'h99aa_bbcc);
  load_and_check(32'h87, LSU_WORD, 1'b0);
  store_and_check(32'h93, LSU_HALF, 32'h0000_beef);
  load_and_check(32'h93, LSU_HALF, 1'b1);
  report_test("misaligned stores");
endtask

task automatic test_bus_errors();
  data_t rd;
  logic  ok;
  logic  lerr;
  logic  serr;
  start_test();
  // aligned load inside the error range
  run_access(1'b0, LSU_WORD, 32'hc4, '0, 1'b0, rd, ok, lerr, serr);
  check_bit("aligned load error", lerr, 1'b1);
  check_bit("aligned load data valid", ok, 1'b0);
  check_addr("last address of aligned load", addr_last_o, 32'hc4);
  // aligned store, memory stays as it was
  run_access(1'b1, LSU_WORD, 32'hc8, 32'h0bad_0bad, 1'b0, rd, ok, lerr, serr);
  check_bit("aligned store error", serr, 1'b1);
  check_bit("load error on store", lerr, 0);
  check_memory();
  // first word fails, second word is fine
  run_access(1'b0, LSU_WORD, 32'hce, '0, 1'b0, rd, ok, lerr, serr);
  check_bit("first half load error", lerr, 1'b1);
  check_bit("first half data valid", ok, 1'b0);
  check_addr("last address after first half error", addr_last_o, 32'hce);
  // first word fine, second word fails
  run_access(1'b0, LSU_WORD, 32'hbd, '0, 1'b0, rd, ok, lerr, serr);
  check_bit("second half load error", lerr, 1'b1);
  check_bit("second half data valid", ok, 1'b0);
  check_addr("last address after second half error", addr_last_o, 32'hc0);
  report_test("bus errors");
endtask

task automatic test_random();
  int        i;
  int        r;
  int        bits;
  addr_t     a;
  lsu_type_e typ;
  data_t     wd;
  start_test();
  for (i = 0; i < 40; i++) begin
    r    = int'($unsigned($random(seed)) % 3);
    typ  = (r == 0) ? LSU_WORD : ((r == 1) ? LSU_HALF : LSU_BYTE);
    // stays below the error range even for a split word
    a    = $unsigned($random(seed)) % 32'hb8;
    wd   = $random(seed);
    bits = $random(seed);
    if (bits[1]) begin
      store_and_check(a, typ, wd);
    end else begin
      load_and_check(a, typ, bits[0]);
    end
  end
  report_test("random accesses");
endtask

`endif

//--- verification/tb_lsu.sv
/*
 * testbench top for the load/store unit
 * clock and reset, bus memory model with random grant and response delays,
 * cycle timeout and result summary
 */
`default_nettype none

module tb_lsu import lsu_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    MemWords      = 64;
  localparam int    TimeoutCycles = 2000;
  // word range that answers with a bus error
  localparam addr_t ErrLo         = 32'h0000_00c0;
  localparam addr_t ErrHi         = 32'h0000_00cf;

  logic      clk_i;
  logic      rst_ni;
  logic      lsu_req_i;
  logic      lsu_we_i;
  lsu_type_e lsu_type_i;
  data_t     lsu_wdata_i;
  logic      lsu_sign_ext_i;
  addr_t     adder_result_ex_i;
  logic      data_req_o;
  logic      data_gnt_i;
  logic      data_rvalid_i;
  logic      data_bus_err_i;
  addr_t     data_addr_o;
  logic      data_we_o;
  be_t       data_be_o;
  data_t     data_wdata_o;
  data_t     data_rdata_i;
  data_t     lsu_rdata_o;
  logic      lsu_rdata_valid_o;
  logic      lsu_resp_valid_o;
  logic      lsu_req_done_o;
  logic      addr_incr_req_o;
  addr_t     addr_last_o;
  logic      load_err_o;
  logic      store_err_o;
  logic      busy_o;

  // bus memory and byte reference model
  data_t      mem [MemWords];
  logic [7:0] ref_mem [4*MemWords];

  // bus model state
  int         seed     = 8041;
  int         cyc      = 0;
  int         gnt_wait = 0;
  int         last_due = 0;
  int         due_q [$];
  data_t      resp_data_q [$];
  logic       resp_err_q [$];
  addr_t      gnt_addr_q [$];
  logic       incr_seen;

  // result bookkeeping
  int         err_cnt        = 0;
  int         check_cnt      = 0;
  int         test_cnt       = 0;
  int         test_start_err = 0;

  lsu_top dut0 (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_type_i        (lsu_type_i),
    .lsu_wdata_i       (lsu_wdata_i),
    .lsu_sign_ext_i    (lsu_sign_ext_i),
    .adder_result_ex_i (adder_result_ex_i),
    .data_req_o        (data_req_o),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .data_addr_o       (data_addr_o),
    .data_we_o         (data_we_o),
    .data_be_o         (data_be_o),
    .data_wdata_o      (data_wdata_o),
    .data_rdata_i      (data_rdata_i),
    .lsu_rdata_o       (lsu_rdata_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_req_done_o    (lsu_req_done_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .addr_last_o       (addr_last_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o)
  );

  always #10 clk_i = ~clk_i;

  ////////////////////
  // bus model
  ////////////////////

  // handshakes are taken at the rising edge, with pre-edge values
  always @(posedge clk_i) begin : bus_accept
    int   idx;
    int   due;
    int   k;
    logic err;
    if (addr_incr_req_o) begin
      incr_seen = 1'b1;
    end
    if (data_req_o && data_gnt_i) begin
      idx = int'(data_addr_o[7:2]);
      err = (data_addr_o >= ErrLo) && (data_addr_o <= ErrHi);
      // failing writes leave memory alone
      if (data_we_o && !err) begin
        for (k = 0; k < 4; k++) begin
          if (data_be_o[k]) begin
            mem[idx][8*k +: 8] = data_wdata_o[8*k +: 8];
          end
        end
      end
      // response 1 to 3 cycles later, never before the one in front
      due = cyc + 1 + int'($unsigned($random(seed)) % 3);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      due_q.push_back(due);
      resp_data_q.push_back(mem[idx]);
      resp_err_q.push_back(err);
      gnt_addr_q.push_back(data_addr_o);
      gnt_wait = int'($unsigned($random(seed)) % 4);
    end else if (data_req_o && (gnt_wait > 0)) begin
      gnt_wait = gnt_wait - 1;
    end
    cyc = cyc + 1;
    if (cyc >= TimeoutCycles) begin
      $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // grant and response lines change on the falling edge
  always @(negedge clk_i) begin
    data_gnt_i = (gnt_wait == 0);
    if ((due_q.size() > 0) && (due_q[0] == cyc)) begin
      void'(due_q.pop_front());
      data_rvalid_i  = 1'b1;
      data_rdata_i   = resp_data_q.pop_front();
      data_bus_err_i = resp_err_q.pop_front();
    end else begin
      data_rvalid_i  = 1'b0;
      data_bus_err_i = 1'b0;
    end
  end

  `include "tb_lsu_tests.svh"

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    int i;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    lsu_req_i         = 1'b0;
    lsu_we_i          = 1'b0;
    lsu_type_i        = LSU_WORD;
    lsu_wdata_i       = '0;
    lsu_sign_ext_i    = 1'b0;
    adder_result_ex_i = '0;
    data_gnt_i        = 1'b0;
    data_rvalid_i     = 1'b0;
    data_bus_err_i    = 1'b0;
    data_rdata_i      = '0;
    incr_seen         = 1'b0;
    // every byte differs from its neighbours and depends on its address
    for (i = 0; i < MemWords; i++) begin
      mem[i] = {8'(4*i+3) ^ 8'h5a, 8'(4*i+2) ^ 8'hc3, 8'(4*i+1) ^ 8'h96, 8'(4*i) ^ 8'h3c};
      ref_mem[4*i]   = mem[i][7:0];
      ref_mem[4*i+1] = mem[i][15:8];
      ref_mem[4*i+2] = mem[i][23:16];
      ref_mem[4*i+3] = mem[i][31:24];
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    test_word_store_load();
    test_sub_word();
    test_misaligned_load();
    test_misaligned_store();
    test_bus_errors();
    test_random();

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/lsu_top.sv
/*
 * load/store unit top level
 * request FSM, store lane aligner and load realigner wired to core and bus ports
 */
`default_nettype none

module lsu_top import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // core request, held until lsu_req_done_o
  input  logic      lsu_req_i,
  input  logic      lsu_we_i,
  input  lsu_type_e lsu_type_i,
  input  data_t     lsu_wdata_i,
  input  logic      lsu_sign_ext_i,
  input  addr_t     adder_result_ex_i,

  // data bus
  output logic      data_req_o,
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  logic      data_bus_err_i,
  output addr_t     data_addr_o,
  output logic      data_we_o,
  output be_t       data_be_o,
  output data_t     data_wdata_o,
  input  data_t     data_rdata_i,

  // results back to the core
  output data_t     lsu_rdata_o,
  output logic      lsu_rdata_valid_o,
  output logic      lsu_resp_valid_o,
  output logic      lsu_req_done_o,
  output logic      addr_incr_req_o,
  output addr_t     addr_last_o,
  output logic      load_err_o,
  output logic      store_err_o,
  output logic      busy_o
);

  // strobes and flags from the FSM
  logic    second_half;
  logic    ctrl_capture;
  logic    rdata_capture;
  addr_t   addr_last;

  // lane offset for the store path
  offset_t store_offset;

  ////////////////////
  // bus address
  ////////////////////

  // bus only sees word addresses, lanes are picked by data_be_o
  assign data_addr_o = {adder_result_ex_i[31:2], 2'b00};
  assign data_we_o   = lsu_we_i;

  // during the second half the core shows the next word, so the
  // original offset is taken from the recorded first address
  assign store_offset = second_half ? addr_last[1:0] : adder_result_ex_i[1:0];

  assign addr_last_o = addr_last;

  ////////////////////
  // submodules
  ////////////////////

  lsu_req_fsm u_req_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .lsu_req_i         (lsu_req_i),
    .lsu_we_i          (lsu_we_i),
    .lsu_type_i        (lsu_type_i),
    .adder_result_ex_i (adder_result_ex_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .data_bus_err_i    (data_bus_err_i),
    .data_req_o        (data_req_o),
    .addr_incr_req_o   (addr_incr_req_o),
    .second_half_o     (second_half),
    .ctrl_capture_o    (ctrl_capture),
    .rdata_capture_o   (rdata_capture),
    .lsu_req_done_o    (lsu_req_done_o),
    .lsu_resp_valid_o  (lsu_resp_valid_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o),
    .load_err_o        (load_err_o),
    .store_err_o       (store_err_o),
    .busy_o            (busy_o),
    .addr_last_o       (addr_last)
  );

  lsu_store_align u_store_align (
    .lsu_type_i    (lsu_type_i),
    .offset_i      (store_offset),
    .second_half_i (second_half),
    .lsu_wdata_i   (lsu_wdata_i),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o)
  );

  // offset is only sampled at the first grant of an access
  lsu_load_align u_load_align (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .ctrl_capture_i  (ctrl_capture),
    .rdata_capture_i (rdata_capture),
    .lsu_type_i      (lsu_type_i),
    .lsu_sign_ext_i  (lsu_sign_ext_i),
    .offset_i        (adder_result_ex_i[1:0]),
    .data_rdata_i    (data_rdata_i),
    .lsu_rdata_o     (lsu_rdata_o)
  );

endmodule

`default_nettype wire

//--- verilog/lsu_load_align.sv
/*
 * load path of the load/store unit
 * captured access control, first-half data register,
 * realignment and zero or sign extension
 */
`default_nettype none

module lsu_load_align import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // strobes from the FSM
  input  logic      ctrl_capture_i,
  input  logic      rdata_capture_i,

  // access control from the core
  input  lsu_type_e lsu_type_i,
  input  logic      lsu_sign_ext_i,
  input  offset_t   offset_i,

  // bus response data
  input  data_t     data_rdata_i,
  output data_t     lsu_rdata_o
);

  // access control held until the final response
  offset_t   offset_q;
  lsu_type_e type_q;
  logic      sign_ext_q;

  // upper three bytes of the first-half response
  logic [DataWidth-1:8] rdata_q;

  // first-half bytes below the second response
  logic [2*DataWidth-9:0] split_win;
  data_t                  rdata_shift;
  data_t                  word_data;
  logic [15:0]            half_data;
  logic [7:0]             byte_data;

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      type_q     <= LSU_WORD;
      sign_ext_q <= 1'b0;
    end else if (ctrl_capture_i) begin
      offset_q   <= offset_i;
      type_q     <= lsu_type_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  // lane 0 of the first half is never part of a split access
  always_ff @(posedge clk_i) begin
    if (rdata_capture_i) begin
      rdata_q <= data_rdata_i[DataWidth-1:8];
    end
  end

  ////////////////////
  // realignment
  ////////////////////

  // accesses that fit in one word, addressed byte moved to lane 0
  assign rdata_shift = data_rdata_i >> {offset_q, 3'b000};

  // split accesses start at byte (offset - 1) of the window
  assign split_win = {data_rdata_i, rdata_q};

  always_comb begin
    if (offset_q == '0) begin
      word_data = data_rdata_i;
    end else begin
      word_data = data_t'(split_win >> {offset_q - 2'd1, 3'b000});
    end
  end

  // halves only span two words at offset 3
  assign half_data = (offset_q == 2'd3) ? word_data[15:0] : rdata_shift[15:0];
  assign byte_data = rdata_shift[7:0];

  ////////////////////
  // extension
  ////////////////////

  always_comb begin
    unique case (type_q)
      LSU_WORD: begin
        lsu_rdata_o = word_data;
      end
      LSU_HALF: begin
        lsu_rdata_o = {{(DataWidth-16){sign_ext_q & half_data[15]}}, half_data};
      end
      // both byte codes
      default: begin
        lsu_rdata_o = {{(DataWidth-8){sign_ext_q & byte_data[7]}}, byte_data};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/lsu_store_align.sv
/*
 * store path of the load/store unit
 * byte-enable selection and store-data lane rotation
 */
`default_nettype none

module lsu_store_align import lsu_pkg::*; (
  input  lsu_type_e lsu_type_i,
  input  offset_t   offset_i,
  input  logic      second_half_i,
  input  data_t     lsu_wdata_i,
  output be_t       data_be_o,
  output data_t     data_wdata_o
);

  // base masks before shifting to the offset
  localparam be_t BeAll  = '1;
  localparam be_t BeHalf = be_t'(2'b11);
  localparam be_t BeOne  = be_t'(1'b1);

  // store data doubled so a plain shift gives a rotation
  logic [2*DataWidth-1:0] wdata_dbl;

  ////////////////////
  // byte enables
  ////////////////////

  // shifted masks drop lanes past lane 3, which go to the second half
  always_comb begin
    unique case (lsu_type_i)
      LSU_WORD: begin
        if (!second_half_i) begin
          // offset lane up to the top lane
          data_be_o = BeAll << offset_i;
        end else begin
          // the lanes that did not fit in the first word
          data_be_o = ~(BeAll << offset_i);
        end
      end

      LSU_HALF: begin
        if (!second_half_i) begin
          data_be_o = BeHalf << offset_i;
        end else begin
          // only split at offset 3, upper byte lands in lane 0
          data_be_o = BeOne;
        end
      end

      // byte, never split
      default: begin
        data_be_o = BeOne << offset_i;
      end
    endcase
  end

  ////////////////////
  // data rotation
  ////////////////////

  // rotate left by the offset in bytes
  // byte n of the store data sits on lane (n + offset) mod 4,
  // so the same word serves both halves
  assign wdata_dbl    = {lsu_wdata_i, lsu_wdata_i} << {offset_i, 3'b000};
  assign data_wdata_o = wdata_dbl[2*DataWidth-1:DataWidth];

endmodule

`default_nettype wire

//--- verilog/lsu_req_fsm.sv
/*
 * bus request FSM for the load/store unit
 * misaligned split, first-half error tracking, last-address register
 */
`default_nettype none

module lsu_req_fsm import lsu_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // core request
  input  logic      lsu_req_i,
  input  logic      lsu_we_i,
  input  lsu_type_e lsu_type_i,
  input  addr_t     adder_result_ex_i,

  // bus handshake
  input  logic      data_gnt_i,
  input  logic      data_rvalid_i,
  input  logic      data_bus_err_i,
  output logic      data_req_o,

  // to the core and the datapath
  output logic      addr_incr_req_o,
  output logic      second_half_o,
  output logic      ctrl_capture_o,
  output logic      rdata_capture_o,
  output logic      lsu_req_done_o,
  output logic      lsu_resp_valid_o,
  output logic      lsu_rdata_valid_o,
  output logic      load_err_o,
  output logic      store_err_o,
  output logic      busy_o,
  output addr_t     addr_last_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_GNT_MIS,
    ST_WAIT_RESP_MIS,
    ST_WAIT_GNT,
    ST_WAIT_RESP_MIS_GNTS_DONE
  } state_e;

  state_e  state_q, state_d;
  offset_t offset;
  logic    split;
  // set between the first grant and the second grant of a split access
  logic    second_half_q, second_half_d;
  // bus error seen on the first half
  logic    err_q, err_d;
  logic    we_q;
  logic    addr_update;
  addr_t   addr_last_q;
  logic    resp_err;

  assign offset = adder_result_ex_i[1:0];

  // words at any nonzero offset and halves at offset 3 cross a word
  assign split = ((lsu_type_i == LSU_WORD) && (offset != '0)) ||
                 ((lsu_type_i == LSU_HALF) && (offset == 2'd3));

  ////////////////////
  // next state
  ////////////////////

  always_comb begin
    state_d         = state_q;
    second_half_d   = second_half_q;
    err_d           = err_q;
    data_req_o      = 1'b0;
    addr_incr_req_o = 1'b0;
    addr_update     = 1'b0;
    ctrl_capture_o  = 1'b0;
    rdata_capture_o = 1'b0;

    unique case (state_q)
      ST_IDLE: begin
        if (lsu_req_i) begin
          data_req_o = 1'b1;
          // new access starts with a clean error
          err_d      = 1'b0;
          if (data_gnt_i) begin
            ctrl_capture_o = 1'b1;
            addr_update    = 1'b1;
            second_half_d  = split;
            state_d        = split ? ST_WAIT_RESP_MIS : ST_IDLE;
          end else begin
            state_d = split ? ST_WAIT_GNT_MIS : ST_WAIT_GNT;
          end
        end
      end

      ST_WAIT_GNT_MIS: begin
        // first half still waiting for its grant
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_capture_o = 1'b1;
          addr_update    = 1'b1;
          second_half_d  = 1'b1;
          state_d        = ST_WAIT_RESP_MIS;
        end
      end

      ST_WAIT_RESP_MIS: begin
        // second half goes out while the first response is pending
        data_req_o      = 1'b1;
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d           = data_bus_err_i;
          rdata_capture_o = ~we_q;
          // keep the failing first address for trap reporting
          addr_update     = data_gnt_i & ~data_bus_err_i;
          second_half_d   = ~data_gnt_i;
          state_d         = data_gnt_i ? ST_IDLE : ST_WAIT_GNT;
        end else if (data_gnt_i) begin
          second_half_d = 1'b0;
          state_d       = ST_WAIT_RESP_MIS_GNTS_DONE;
        end
      end

      ST_WAIT_GNT: begin
        // aligned access or second half, waiting for grant
        data_req_o      = 1'b1;
        addr_incr_req_o = second_half_q;
        if (data_gnt_i) begin
          // control was already taken at the first grant of a split access
          ctrl_capture_o = ~second_half_q;
          addr_update    = ~err_q;
          second_half_d  = 1'b0;
          state_d        = ST_IDLE;
        end
      end

      ST_WAIT_RESP_MIS_GNTS_DONE: begin
        // both halves granted, core keeps the second address up
        addr_incr_req_o = 1'b1;
        if (data_rvalid_i) begin
          err_d           = data_bus_err_i;
          rdata_capture_o = ~we_q;
          addr_update     = ~data_bus_err_i;
          state_d         = ST_IDLE;
        end
      end

      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= ST_IDLE;
      second_half_q <= 1'b0;
      err_q         <= 1'b0;
    end else begin
      state_q       <= state_d;
      second_half_q <= second_half_d;
      err_q         <= err_d;
    end
  end

  // direction of the access in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_q <= 1'b0;
    end else if (ctrl_capture_o) begin
      we_q <= lsu_we_i;
    end
  end

  // byte address of the first half, word address of the second half
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_last_q <= '0;
    end else if (addr_update) begin
      addr_last_q <= addr_incr_req_o ? {adder_result_ex_i[31:2], 2'b00} : adder_result_ex_i;
    end
  end

  ////////////////////
  // outputs
  ////////////////////

  // either half failing fails the whole access
  assign resp_err = err_q | data_bus_err_i;

  // the final response always arrives back in idle
  assign lsu_resp_valid_o  = data_rvalid_i & (state_q == ST_IDLE);
  assign lsu_rdata_valid_o = lsu_resp_valid_o & ~resp_err & ~we_q;
  assign load_err_o        = lsu_resp_valid_o & resp_err & ~we_q;
  assign store_err_o       = lsu_resp_valid_o & resp_err & we_q;

  // done once no further grant is needed
  assign lsu_req_done_o = (lsu_req_i | (state_q != ST_IDLE)) & (state_d == ST_IDLE);

  assign busy_o        = (state_q != ST_IDLE);
  assign second_half_o = second_half_q;
  assign addr_last_o   = addr_last_q;

endmodule

`default_nettype wire

//--- verilog/lsu_pkg.sv
/*
 * load/store unit shared definitions
 * data and lane widths, access-size encoding, address/data/byte-enable types
 */
`default_nettype none

package lsu_pkg;

  ////////////////////
  // widths
  ////////////////////

  // register and bus data width
  localparam int unsigned DataWidth = 32;
  // one enable per byte lane
  localparam int unsigned BeWidth   = DataWidth / 8;

  ////////////////////
  // types
  ////////////////////

  // byte address as produced by the execute stage adder
  typedef logic [31:0] addr_t;

  // one bus or register word
  typedef logic [DataWidth-1:0] data_t;

  // byte-enable mask, bit n enables lane n
  typedef logic [BeWidth-1:0] be_t;

  // byte position inside a word
  typedef logic [$clog2(BeWidth)-1:0] offset_t;

  // access size from the decoder
  // the unused code 2'b11 is treated as a byte access everywhere
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsu_type_e;

endpackage

`default_nettype wire
